// File: project.f
verilog/dram_bridge_pkg.sv
verilog/sync_fifo.sv
verilog/lane_formatter.sv
verilog/request_fsm.sv
verilog/cmd_issue_fsm.sv
verilog/dram_bridge_top.sv
tests/tb_dram_bridge.sv

// File: run.sh
#!/bin/sh
# build the DRAM bridge testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --top-module tb_dram_bridge -f project.f \
    && sim_out=$(./obj_dir/Vtb_dram_bridge)
echo "$sim_out"
echo "$sim_out" | grep -qx "ALL CHECKS PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: tests/tb_dram_bridge.sv
/* stimulus table with expected lines, application-side memory model
   with random ready stalls, checks and timeout of the DRAM bridge */
`timescale 1ns/1ps

module tb_dram_bridge;

    import dram_bridge_pkg::*;

    localparam int          ROWS         = 13;
    localparam int          RESET_CYCLES = 16;
    localparam int          DRIVE_DELAY  = 2;
    localparam int          CYCLE_LIMIT  = ROWS * 60 + 100;
    localparam logic [31:0] RAND_SEED    = 32'he26e;

    logic                       clk;
    logic                       rst_x_async;
    logic                       i_wr_en;
    logic                       i_rd_en;
    logic [USER_ADDR_WIDTH-1:0] i_addr;
    logic [WORD_WIDTH-1:0]      i_data;
    logic [BYTE_LANES-1:0]      i_mask;
    logic                       o_busy;
    line_t                      o_data;
    logic                       i_calib_complete;
    logic                       i_app_rdy;
    logic                       i_app_wdf_rdy;
    line_t                      i_app_rd_data;
    logic                       i_app_rd_data_valid;
    logic                       o_app_en;
    app_cmd_t                   o_app_cmd;
    logic [APP_ADDR_WIDTH-1:0]  o_app_addr;
    line_t                      o_app_wdf_data;
    logic                       o_app_wdf_wren;
    logic                       o_app_wdf_end;
    logic [APP_MASK_WIDTH-1:0]  o_app_wdf_mask;

    // stimulus table with the expected line of each read
    logic        row_wr   [ROWS];
    logic [31:0] row_addr [ROWS];
    logic [31:0] row_data [ROWS];
    logic [3:0]  row_mask [ROWS];
    line_t       row_line [ROWS];

    // user-side reference words by word address
    logic [31:0] ref_words [logic [24:0]];

    // application-side model
    line_t       app_mem [logic [27:0]];
    logic [27:0] wr_addr_q [$];
    line_t       wr_data_q [$];
    logic [15:0] wr_mask_q [$];
    int          cmd_seen;
    int          wdf_seen;
    int          wdf_row;
    int          rd_wait;
    logic        rd_busy;
    line_t       rd_line;

    int value_errors = 0;
    int flow_errors  = 0;
    int cycle_count  = 0;

    dram_bridge_top #(
        .FIFO_DEPTH_LOG2 (2)
    ) dram_bridge_top_i (
        .clk                 (clk),
        .rst_x_async         (rst_x_async),
        .i_wr_en             (i_wr_en),
        .i_rd_en             (i_rd_en),
        .i_addr              (i_addr),
        .i_data              (i_data),
        .i_mask              (i_mask),
        .o_busy              (o_busy),
        .o_data              (o_data),
        .i_calib_complete    (i_calib_complete),
        .i_app_rdy           (i_app_rdy),
        .i_app_wdf_rdy       (i_app_wdf_rdy),
        .i_app_rd_data       (i_app_rd_data),
        .i_app_rd_data_valid (i_app_rd_data_valid),
        .o_app_en            (o_app_en),
        .o_app_cmd           (o_app_cmd),
        .o_app_addr          (o_app_addr),
        .o_app_wdf_data      (o_app_wdf_data),
        .o_app_wdf_wren      (o_app_wdf_wren),
        .o_app_wdf_end       (o_app_wdf_end),
        .o_app_wdf_mask      (o_app_wdf_mask)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // line address from address bits 26..4 and three zero bits
    function automatic logic [27:0] line_addr(input logic [31:0] addr);
        return {2'b00, addr[26:4], 3'b000};
    endfunction

    // initial memory content unique per line address and lane
    function automatic logic [31:0] fill_word(input logic [27:0] a, input logic [1:0] lane);
        return {a, lane, 2'b01};
    endfunction

    function automatic line_t fill_line(input logic [27:0] a);
        line_t line;
        int    i;
        for (i = 0; i < 4; i++) begin
            line[32*i +: 32] = fill_word(a, 2'(i));
        end
        return line;
    endfunction

    // bytes outside the addressed word lane are kept
    function automatic logic [15:0] lane_mask(input logic [31:0] addr, input logic [3:0] mask);
        logic [15:0] m;
        int          b;
        for (b = 0; b < 16; b++) begin
            m[b] = (b / 4 == int'(addr[3:2])) ? mask[b % 4] : 1'b1;
        end
        return m;
    endfunction

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        assert (got === exp) else begin
            $display("FAILED at %0d ns: %s is %h, expected %h", $time, name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            $display("error at %0d ns: %s", $time, what);
            flow_errors++;
        end
    endtask

    task automatic print_counts();
        $display("value errors: %0d, handshake errors: %0d", value_errors, flow_errors);
    endtask

    task automatic set_row(input int idx, input logic wr, input logic [31:0] addr,
                           input logic [31:0] data, input logic [3:0] mask);
        row_wr[idx]   = wr;
        row_addr[idx] = addr;
        row_data[idx] = data;
        row_mask[idx] = mask;
    endtask

    task automatic fill_table();
        // four lanes of one line and the merged read
        set_row(0,  1'b1, 32'h0000_0100, 32'h1111_1111, 4'b0000);
        set_row(1,  1'b1, 32'h0000_0104, 32'h2222_2222, 4'b0000);
        set_row(2,  1'b1, 32'h0000_0108, 32'h3333_3333, 4'b0000);
        set_row(3,  1'b1, 32'h0000_010C, 32'h4444_4444, 4'b0000);
        set_row(4,  1'b0, 32'h0000_0100, 32'h0,         4'b0000);
        // partial masks
        set_row(5,  1'b1, 32'h0000_0204, 32'hA5A5_A5A5, 4'b0101);
        set_row(6,  1'b1, 32'h0000_0208, 32'h5A5A_5A5A, 4'b1010);
        set_row(7,  1'b0, 32'h0000_0200, 32'h0,         4'b0000);
        set_row(8,  1'b1, 32'h0123_4568, 32'hDEAD_BEEF, 4'b1100);
        // bit 27 lies outside the line address
        set_row(9,  1'b1, 32'h0F00_0FF0, 32'hCAFE_F00D, 4'b0000);
        set_row(10, 1'b0, 32'h0123_4560, 32'h0,         4'b0000);
        set_row(11, 1'b0, 32'h0700_0FF0, 32'h0,         4'b0000);
        set_row(12, 1'b0, 32'h0000_0300, 32'h0,         4'b0000);
    endtask

    // expected read lines from the table rows before each read
    task automatic build_expected();
        logic [24:0] key;
        logic [31:0] word;
        line_t       line;
        int          r;
        int          i;
        int          b;
        for (r = 0; r < ROWS; r++) begin
            if (row_wr[r]) begin
                key = row_addr[r][26:2];
                if (ref_words.exists(key)) begin
                    word = ref_words[key];
                end else begin
                    word = fill_word(line_addr(row_addr[r]), row_addr[r][3:2]);
                end
                for (b = 0; b < 4; b++) begin
                    if (!row_mask[r][b]) begin
                        word[8*b +: 8] = row_data[r][8*b +: 8];
                    end
                end
                ref_words[key] = word;
                row_line[r]    = '0;
            end else begin
                for (i = 0; i < 4; i++) begin
                    key = {row_addr[r][26:4], 2'(i)};
                    line[32*i +: 32] = ref_words.exists(key) ? ref_words[key]
                                       : fill_word(line_addr(row_addr[r]), 2'(i));
                end
                row_line[r] = line;
            end
        end
    endtask

    task automatic expect_quiet();
        check_value("o_busy", 128'(o_busy), 128'(1'b1));
        check_value("o_app_en", 128'(o_app_en), 128'(1'b0));
        check_value("o_app_wdf_wren", 128'(o_app_wdf_wren), 128'(1'b0));
    endtask

    task automatic run_row(input int r);
        @(negedge clk);
        while (o_busy) begin
            @(negedge clk);
        end
        @(posedge clk);
        #DRIVE_DELAY;
        i_wr_en = row_wr[r];
        i_rd_en = !row_wr[r];
        i_addr  = row_addr[r];
        i_data  = row_data[r];
        i_mask  = row_mask[r];
        @(posedge clk);
        #DRIVE_DELAY;
        i_wr_en = 1'b0;
        i_rd_en = 1'b0;
        @(negedge clk);
        check_value("o_busy", 128'(o_busy), 128'(1'b1));
        while (o_busy) begin
            @(negedge clk);
        end
        if (!row_wr[r]) begin
            check_value("o_data", o_data, row_line[r]);
        end
    endtask

    task automatic take_command();
        int r;
        r = cmd_seen;
        check_true(r < ROWS, "command accepted after the last table row");
        if (r < ROWS) begin
            check_value("o_app_cmd", 128'(o_app_cmd),
                        row_wr[r] ? 128'(CMD_WRITE) : 128'(CMD_READ));
            check_value("o_app_addr", 128'(o_app_addr), 128'(line_addr(row_addr[r])));
            if (o_app_cmd == CMD_WRITE) begin
                wr_addr_q.push_back(o_app_addr);
            end else begin
                rd_line = app_mem.exists(o_app_addr) ? app_mem[o_app_addr]
                                                     : fill_line(o_app_addr);
                rd_wait = 1 + int'($urandom % 5);
                rd_busy = 1'b1;
            end
            cmd_seen++;
        end
    endtask

    task automatic take_write_data();
        while (wdf_row < ROWS && !row_wr[wdf_row]) begin
            wdf_row++;
        end
        check_true(wdf_row < ROWS, "write data accepted after the last table write");
        if (wdf_row < ROWS) begin
            check_value("o_app_wdf_data", o_app_wdf_data, {4{row_data[wdf_row]}});
            check_value("o_app_wdf_mask", 128'(o_app_wdf_mask),
                        128'(lane_mask(row_addr[wdf_row], row_mask[wdf_row])));
            check_value("o_app_wdf_end", 128'(o_app_wdf_end), 128'(1'b1));
            wr_data_q.push_back(o_app_wdf_data);
            wr_mask_q.push_back(o_app_wdf_mask);
            wdf_row++;
            wdf_seen++;
        end
    endtask

    // pair write commands with write data and update the model lines
    task automatic apply_writes();
        logic [27:0] a;
        line_t       d;
        logic [15:0] m;
        line_t       line;
        int          b;
        while (wr_addr_q.size() > 0 && wr_data_q.size() > 0) begin
            a    = wr_addr_q.pop_front();
            d    = wr_data_q.pop_front();
            m    = wr_mask_q.pop_front();
            line = app_mem.exists(a) ? app_mem[a] : fill_line(a);
            for (b = 0; b < 16; b++) begin
                if (!m[b]) begin
                    line[8*b +: 8] = d[8*b +: 8];
                end
            end
            app_mem[a] = line;
        end
    endtask

    // memory controller side with random ready and delayed read return
    initial begin
        void'($urandom(RAND_SEED));
        i_app_rdy           = 1'b0;
        i_app_wdf_rdy       = 1'b0;
        i_app_rd_data       = '0;
        i_app_rd_data_valid = 1'b0;
        cmd_seen            = 0;
        wdf_seen            = 0;
        wdf_row             = 0;
        rd_wait             = 0;
        rd_busy             = 1'b0;
        forever begin
            @(posedge clk);
            #DRIVE_DELAY;
            i_app_rdy           = 1'($urandom % 2);
            i_app_wdf_rdy       = 1'($urandom % 2);
            i_app_rd_data_valid = 1'b0;
            if (rd_busy) begin
                if (rd_wait == 0) begin
                    i_app_rd_data       = rd_line;
                    i_app_rd_data_valid = 1'b1;
                    rd_busy             = 1'b0;
                end else begin
                    rd_wait--;
                end
            end
            // acceptances as seen by the next rising edge
            @(negedge clk);
            if (rst_x_async) begin
                if (o_app_wdf_wren && i_app_wdf_rdy) begin
                    take_write_data();
                end
                if (o_app_en && i_app_rdy) begin
                    take_command();
                end
                apply_writes();
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("timeout: run exceeded %0d cycles", CYCLE_LIMIT);
            print_counts();
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        int k;
        int r;
        int write_rows;
        rst_x_async      = 1'b0;
        i_calib_complete = 1'b0;
        i_wr_en          = 1'b0;
        i_rd_en          = 1'b0;
        i_addr           = '0;
        i_data           = '0;
        i_mask           = '0;
        fill_table();
        build_expected();

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_x_async = 1'b1;

        // calibration still pending
        repeat (8) begin
            @(negedge clk);
            expect_quiet();
        end
        @(posedge clk);
        #DRIVE_DELAY;
        i_calib_complete = 1'b1;
        // two synchronizer stages and then the state change
        for (k = 1; k <= 3; k++) begin
            @(posedge clk);
            @(negedge clk);
            check_value("o_busy", 128'(o_busy), 128'(k < 3));
        end

        for (r = 0; r < ROWS; r++) begin
            run_row(r);
        end

        write_rows = 0;
        for (r = 0; r < ROWS; r++) begin
            write_rows += int'(row_wr[r]);
        end
        check_true(cmd_seen == ROWS, "number of accepted commands differs from the table");
        check_true(wdf_seen == write_rows, "number of accepted write data beats is wrong");
        check_true(wr_addr_q.size() == 0 && wr_data_q.size() == 0,
                   "write command and write data left unpaired");

        print_counts();
        if (value_errors + flow_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: verilog/dram_bridge_top.sv
/* DRAM bridge top: request FSM, request and read line queues,
   lane formatter and command issue FSM */
`timescale 1ns/1ps

module dram_bridge_top #(
    parameter int FIFO_DEPTH_LOG2 = 2
) (
    input  logic                                        clk,
    input  logic                                        rst_x_async,
    // user port
    input  logic                                        i_wr_en,
    input  logic                                        i_rd_en,
    input  logic [dram_bridge_pkg::USER_ADDR_WIDTH-1:0] i_addr,
    input  logic [dram_bridge_pkg::WORD_WIDTH-1:0]      i_data,
    input  logic [dram_bridge_pkg::BYTE_LANES-1:0]      i_mask,
    output logic                                        o_busy,
    output dram_bridge_pkg::line_t                      o_data,
    input  logic                                        i_calib_complete,
    // application interface
    input  logic                                        i_app_rdy,
    input  logic                                        i_app_wdf_rdy,
    input  dram_bridge_pkg::line_t                      i_app_rd_data,
    input  logic                                        i_app_rd_data_valid,
    output logic                                        o_app_en,
    output dram_bridge_pkg::app_cmd_t                   o_app_cmd,
    output logic [dram_bridge_pkg::APP_ADDR_WIDTH-1:0]  o_app_addr,
    output dram_bridge_pkg::line_t                      o_app_wdf_data,
    output logic                                        o_app_wdf_wren,
    output logic                                        o_app_wdf_end,
    output logic [dram_bridge_pkg::APP_MASK_WIDTH-1:0]  o_app_wdf_mask
);

    import dram_bridge_pkg::*;

    // request path
    logic                      req_push;
    req_t                      req_in;
    logic                      req_pop;
    req_t                      req_head;
    logic                      req_empty;
    logic                      req_full;

    // formatted head entry
    logic [APP_ADDR_WIDTH-1:0] fmt_addr;
    line_t                     fmt_data;
    logic [APP_MASK_WIDTH-1:0] fmt_mask;
    app_cmd_t                  fmt_cmd;

    // read return
    logic                      line_pop;
    line_t                     line_head;
    logic                      line_empty;

    request_fsm request_fsm_i (
        .clk              (clk),
        .rst_x_async      (rst_x_async),
        .i_calib_complete (i_calib_complete),
        .i_wr_en          (i_wr_en),
        .i_rd_en          (i_rd_en),
        .i_addr           (i_addr),
        .i_data           (i_data),
        .i_mask           (i_mask),
        .i_req_full       (req_full),
        .i_line_empty     (line_empty),
        .i_line           (line_head),
        .o_req_push       (req_push),
        .o_req            (req_in),
        .o_line_pop       (line_pop),
        .o_busy           (o_busy),
        .o_data           (o_data)
    );

    sync_fifo #(
        .entry_t         (req_t),
        .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
    ) req_fifo_i (
        .clk         (clk),
        .rst_x_async (rst_x_async),
        .i_push      (req_push),
        .i_data      (req_in),
        .i_pop       (req_pop),
        .o_data      (req_head),
        .o_empty     (req_empty),
        .o_full      (req_full)
    );

    lane_formatter lane_formatter_i (
        .i_req      (req_head),
        .o_app_addr (fmt_addr),
        .o_app_data (fmt_data),
        .o_app_mask (fmt_mask),
        .o_app_cmd  (fmt_cmd)
    );

    cmd_issue_fsm cmd_issue_fsm_i (
        .clk            (clk),
        .rst_x_async    (rst_x_async),
        .i_req_empty    (req_empty),
        .i_app_addr     (fmt_addr),
        .i_app_data     (fmt_data),
        .i_app_mask     (fmt_mask),
        .i_app_cmd      (fmt_cmd),
        .i_app_rdy      (i_app_rdy),
        .i_app_wdf_rdy  (i_app_wdf_rdy),
        .o_req_pop      (req_pop),
        .o_app_en       (o_app_en),
        .o_app_cmd      (o_app_cmd),
        .o_app_addr     (o_app_addr),
        .o_app_wdf_data (o_app_wdf_data),
        .o_app_wdf_wren (o_app_wdf_wren),
        .o_app_wdf_end  (o_app_wdf_end),
        .o_app_wdf_mask (o_app_wdf_mask)
    );

    // only one read in flight, full never asserts here
    sync_fifo #(
        .entry_t         (line_t),
        .FIFO_DEPTH_LOG2 (FIFO_DEPTH_LOG2)
    ) line_fifo_i (
        .clk         (clk),
        .rst_x_async (rst_x_async),
        .i_push      (i_app_rd_data_valid),
        .i_data      (i_app_rd_data),
        .i_pop       (line_pop),
        .o_data      (line_head),
        .o_empty     (line_empty),
        .o_full      ()
    );

endmodule

// File: verilog/cmd_issue_fsm.sv
/* drives the application command and write data channels from the request queue,
   each channel held until its own ready */
`timescale 1ns/1ps

module cmd_issue_fsm (
    input  logic                                        clk,
    input  logic                                        rst_x_async,
    input  logic                                        i_req_empty,
    input  logic [dram_bridge_pkg::APP_ADDR_WIDTH-1:0]  i_app_addr,
    input  dram_bridge_pkg::line_t                      i_app_data,
    input  logic [dram_bridge_pkg::APP_MASK_WIDTH-1:0]  i_app_mask,
    input  dram_bridge_pkg::app_cmd_t                   i_app_cmd,
    input  logic                                        i_app_rdy,
    input  logic                                        i_app_wdf_rdy,
    output logic                                        o_req_pop,
    output logic                                        o_app_en,
    output dram_bridge_pkg::app_cmd_t                   o_app_cmd,
    output logic [dram_bridge_pkg::APP_ADDR_WIDTH-1:0]  o_app_addr,
    output dram_bridge_pkg::line_t                      o_app_wdf_data,
    output logic                                        o_app_wdf_wren,
    output logic                                        o_app_wdf_end,
    output logic [dram_bridge_pkg::APP_MASK_WIDTH-1:0]  o_app_wdf_mask
);

    import dram_bridge_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ISSUE_CMD_WDATA,
        ST_ISSUE_CMD,
        ST_ISSUE_WDATA
    } state_t;

    state_t state;
    logic   item_done;
    logic   head_is_write;

    // nothing left pending for the current item
    always_comb begin
        case (state)
            ST_IDLE:            item_done = 1'b1;
            ST_ISSUE_CMD_WDATA: item_done = i_app_rdy & i_app_wdf_rdy;
            ST_ISSUE_CMD:       item_done = i_app_rdy;
            ST_ISSUE_WDATA:     item_done = i_app_wdf_rdy;
            default:            item_done = 1'b1;
        endcase
    end

    assign o_req_pop     = item_done & ~i_req_empty;
    assign head_is_write = (i_app_cmd == CMD_WRITE);

    // one beat per line, so end follows wren
    assign o_app_wdf_end = o_app_wdf_wren;

    // head item registered on each pop
    always_ff @(posedge clk) begin
        if (o_req_pop) begin
            o_app_cmd      <= i_app_cmd;
            o_app_addr     <= i_app_addr;
            o_app_wdf_data <= i_app_data;
            o_app_wdf_mask <= i_app_mask;
        end
    end

    always_ff @(posedge clk or negedge rst_x_async) begin
        if (!rst_x_async) begin
            state          <= ST_IDLE;
            o_app_en       <= 1'b0;
            o_app_wdf_wren <= 1'b0;
        end else begin
            if (o_req_pop) begin
                // next item back to back
                o_app_en       <= 1'b1;
                o_app_wdf_wren <= head_is_write;
                state          <= head_is_write ? ST_ISSUE_CMD_WDATA : ST_ISSUE_CMD;
            end else if (item_done) begin
                o_app_en       <= 1'b0;
                o_app_wdf_wren <= 1'b0;
                state          <= ST_IDLE;
            end else begin
                case (state)
                    ST_ISSUE_CMD_WDATA: begin
                        // drop whichever side got accepted first
                        if (i_app_rdy) begin
                            o_app_en <= 1'b0;
                            state    <= ST_ISSUE_WDATA;
                        end else if (i_app_wdf_rdy) begin
                            o_app_wdf_wren <= 1'b0;
                            state          <= ST_ISSUE_CMD;
                        end
                    end
                    default: begin
                        // ISSUE_CMD and ISSUE_WDATA just hold
                        state <= state;
                    end
                endcase
            end
        end
    end

endmodule

// File: verilog/request_fsm.sv
/* user-side control: calibration synchronizer, request capture and push,
   busy level and read line return */
`timescale 1ns/1ps

module request_fsm (
    input  logic                                         clk,
    input  logic                                         rst_x_async,
    input  logic                                         i_calib_complete,
    input  logic                                         i_wr_en,
    input  logic                                         i_rd_en,
    input  logic [dram_bridge_pkg::USER_ADDR_WIDTH-1:0]  i_addr,
    input  logic [dram_bridge_pkg::WORD_WIDTH-1:0]       i_data,
    input  logic [dram_bridge_pkg::BYTE_LANES-1:0]       i_mask,
    input  logic                                         i_req_full,
    input  logic                                         i_line_empty,
    input  dram_bridge_pkg::line_t                       i_line,
    output logic                                         o_req_push,
    output dram_bridge_pkg::req_t                        o_req,
    output logic                                         o_line_pop,
    output logic                                         o_busy,
    output dram_bridge_pkg::line_t                       o_data
);

    import dram_bridge_pkg::*;

    typedef enum logic [1:0] {
        ST_CALIB,
        ST_IDLE,
        ST_WRITE,
        ST_READ
    } state_t;

    state_t state;
    logic   calib_sync1;
    logic   calib_sync2;
    logic   req_pending;

    // captured request waits here until the queue has room
    assign o_req_push = req_pending & ~i_req_full;
    assign o_line_pop = (state == ST_READ) & ~i_line_empty;
    assign o_busy     = (state != ST_IDLE);

    // calibration status comes from outside
    always_ff @(posedge clk or negedge rst_x_async) begin
        if (!rst_x_async) begin
            calib_sync1 <= 1'b0;
            calib_sync2 <= 1'b0;
        end else begin
            calib_sync1 <= i_calib_complete;
            calib_sync2 <= calib_sync1;
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE) begin
            o_req.wr   <= i_wr_en;
            o_req.addr <= i_addr;
            o_req.data <= i_data;
            o_req.mask <= i_wr_en ? i_mask : {BYTE_LANES{1'b0}};
        end
        if (o_line_pop) begin
            o_data <= i_line;
        end
    end

    always_ff @(posedge clk or negedge rst_x_async) begin
        if (!rst_x_async) begin
            state       <= ST_CALIB;
            req_pending <= 1'b0;
        end else begin
            if (o_req_push) begin
                req_pending <= 1'b0;
            end
            case (state)
                ST_CALIB: begin
                    if (calib_sync2) begin
                        state <= ST_IDLE;
                    end
                end
                ST_IDLE: begin
                    // write wins over a read in the same cycle
                    if (i_wr_en) begin
                        state       <= ST_WRITE;
                        req_pending <= 1'b1;
                    end else if (i_rd_en) begin
                        state       <= ST_READ;
                        req_pending <= 1'b1;
                    end
                end
                ST_WRITE: begin
                    if (!i_req_full) begin
                        state <= ST_IDLE;
                    end
                end
                ST_READ: begin
                    if (!i_line_empty) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// File: verilog/lane_formatter.sv
/* maps a queued request onto the 16-bit DDR3 line format:
   line address, replicated word and per-byte line mask */
`timescale 1ns/1ps

module lane_formatter (
    input  dram_bridge_pkg::req_t                          i_req,
    output logic [dram_bridge_pkg::APP_ADDR_WIDTH-1:0]     o_app_addr,
    output dram_bridge_pkg::line_t                         o_app_data,
    output logic [dram_bridge_pkg::APP_MASK_WIDTH-1:0]     o_app_mask,
    output dram_bridge_pkg::app_cmd_t                      o_app_cmd
);

    import dram_bridge_pkg::*;

    logic [BYTE_LANES-1:0]     keep_word;
    logic [APP_MASK_WIDTH-1:0] keep_line;
    logic [3:0]                lane_shift;

    // word lane inside the line, in bytes
    assign lane_shift = {i_req.addr[3:2], 2'b00};

    always_comb begin
        // 1 in keep_word means the byte gets written
        keep_word = ~i_req.mask;
        keep_line = {{(APP_MASK_WIDTH - BYTE_LANES){1'b0}}, keep_word} << lane_shift;

        o_app_addr = {{(APP_ADDR_WIDTH - 26){1'b0}}, i_req.addr[26:4], 3'b000};
        o_app_data = {(APP_DATA_WIDTH / WORD_WIDTH){i_req.data}};

        if (i_req.wr) begin
            // bytes outside the addressed word stay masked
            o_app_mask = ~keep_line;
            o_app_cmd  = CMD_WRITE;
        end else begin
            o_app_mask = '0;
            o_app_cmd  = CMD_READ;
        end
    end

endmodule

// File: verilog/sync_fifo.sv
/* single-clock FIFO with a type-parameter entry and a combinational head */
`timescale 1ns/1ps

module sync_fifo #(
    parameter type entry_t         = logic [7:0],
    parameter int  FIFO_DEPTH_LOG2 = 2
) (
    input  logic   clk,
    input  logic   rst_x_async,
    input  logic   i_push,
    input  entry_t i_data,
    input  logic   i_pop,
    output entry_t o_data,
    output logic   o_empty,
    output logic   o_full
);

    localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;

    entry_t                   mem [DEPTH];
    logic [FIFO_DEPTH_LOG2-1:0] wr_ptr;
    logic [FIFO_DEPTH_LOG2-1:0] rd_ptr;
    logic [FIFO_DEPTH_LOG2:0]   count;
    logic                       do_push;
    logic                       do_pop;

    // push when full and pop when empty are dropped
    assign do_push = i_push & ~o_full;
    assign do_pop  = i_pop & ~o_empty;

    assign o_empty = (count == '0);
    assign o_full  = (count == (FIFO_DEPTH_LOG2 + 1)'(DEPTH));
    assign o_data  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_data;
        end
    end

    always_ff @(posedge clk or negedge rst_x_async) begin
        if (!rst_x_async) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // occupancy
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: verilog/dram_bridge_pkg.sv
/* shared widths, application command codes,
   request entry and read line types of the DRAM bridge */
package dram_bridge_pkg;

    // user side
    localparam int WORD_WIDTH      = 32;
    localparam int USER_ADDR_WIDTH = 32;
    localparam int BYTE_LANES      = 4;

    // application interface of the memory controller
    localparam int APP_DATA_WIDTH  = 128;
    localparam int APP_MASK_WIDTH  = 16;
    localparam int APP_ADDR_WIDTH  = 28;
    localparam int APP_CMD_WIDTH   = 3;

    typedef logic [APP_CMD_WIDTH-1:0] app_cmd_t;

    localparam app_cmd_t CMD_WRITE = 3'd0;
    localparam app_cmd_t CMD_READ  = 3'd1;

    // one queued user request, 69 bits
    typedef struct packed {
        logic                       wr;
        logic [USER_ADDR_WIDTH-1:0] addr;
        logic [WORD_WIDTH-1:0]      data;
        logic [BYTE_LANES-1:0]      mask;
    } req_t;

    // full line as returned by the controller
    typedef logic [APP_DATA_WIDTH-1:0] line_t;

endpackage
